/* hdl/datapath_pkg.sv */
/* word width is fixed at 32 by the instruction format and is not a parameter
   selects at or above num_regs name no register and are ignored by the datapath */
`default_nettype none

package datapath_pkg;

	// one bus word, set by the 32-bit instruction format
	localparam int data_width = 32;
	typedef logic [data_width-1:0] word_t;

	// a 6-bit select reaches 64 codes but only 38 registers exist
	typedef logic [5:0] reg_sel_t;
	localparam int num_regs = 38;

	// register map, r2 to r30 sit between r1 and r31 in order
	localparam int reg_r0 = 0;
	localparam int reg_r1 = 1;
	localparam int reg_pc = 32;
	localparam int reg_t0 = 33;
	localparam int reg_t1 = 34;
	localparam int reg_t2 = 35;
	localparam int reg_t3 = 36;
	localparam int reg_ir = 37;

	// ------------------------------------------------------------------
	// instruction register fields, as lsb position and width
	// ------------------------------------------------------------------
	localparam int ir_op_lsb = 30;
	localparam int ir_op_width = 2;
	localparam int ir_rd_lsb = 25;
	localparam int ir_rd_width = 5;
	// op2 and op3 overlap, the opcode class picks which one applies
	localparam int ir_op2_lsb = 22;
	localparam int ir_op2_width = 3;
	localparam int ir_op3_lsb = 19;
	localparam int ir_op3_width = 6;
	localparam int ir_rs1_lsb = 14;
	localparam int ir_rs1_width = 5;
	localparam int ir_bit13_lsb = 13;
	localparam int ir_bit13_width = 1;
	localparam int ir_rs2_lsb = 0;
	localparam int ir_rs2_width = 5;

	// codes 0 to 3 are the condition-code operations
	typedef enum logic [3:0] {
		alu_andcc, alu_orcc, alu_norcc, alu_addcc,
		alu_srl, alu_and, alu_or, alu_nor,
		alu_add, alu_lshift2, alu_lshift10, alu_simm13,
		alu_sext13, alu_inc, alu_incpc, alu_rshift5
	} alu_op_t;

	typedef enum logic [1:0] {seq_idle, seq_exec, seq_ack} seq_state_t;

endpackage

`default_nettype wire

/* hdl/micro_sequencer.sv */
/* four-phase req/ack, one micro-operation in flight at a time
   the environment must hold its operation fields stable while req is high */
`timescale 1ns/1ps
`default_nettype none

module micro_sequencer (
	input  logic clock_50,
	input  logic rst_n,
	input  logic req,
	output logic ack,
	output logic exec
);
	import datapath_pkg::*;

	seq_state_t state;
	seq_state_t state_next;

	// ------------------------------------------------------------------
	// next-state logic
	// ------------------------------------------------------------------
	always_comb begin
		state_next = state;
		case (state)
			// wait for a new request, ack is already low here
			seq_idle: begin
				if (req) begin
					state_next = seq_exec;
				end
			end
			// exactly one cycle, the write lands on the edge that leaves it
			seq_exec: begin
				state_next = seq_ack;
			end
			// hold ack until the environment drops req
			seq_ack: begin
				if (!req) begin
					state_next = seq_idle;
				end
			end
			default: begin
				state_next = seq_idle;
			end
		endcase
	end

	always_ff @(posedge clock_50) begin
		if (!rst_n) begin
			state <= seq_idle;
		end else begin
			state <= state_next;
		end
	end

	// both outputs come straight from the state register, so they only
	// move on clock edges
	assign exec = (state == seq_exec);
	assign ack = (state == seq_ack);

endmodule

`default_nettype wire

/* hdl/register_file.sv */
/* r0 and selects of 38 and above read as zero and ignore writes
   a write happens only on the exec strobe, reads are combinational */
`timescale 1ns/1ps
`default_nettype none

module register_file #(
	parameter datapath_pkg::word_t pc_reset_value = 32'h0000_0800
) (
	input  logic                                         clock_50,
	input  logic                                         rst_n,
	input  logic                                         exec,
	input  datapath_pkg::reg_sel_t                       write_sel,
	input  datapath_pkg::reg_sel_t                       bus_a_sel,
	input  datapath_pkg::reg_sel_t                       bus_b_sel,
	input  datapath_pkg::word_t                          bus_c,
	output datapath_pkg::word_t                          bus_a,
	output datapath_pkg::word_t                          bus_b,
	output datapath_pkg::word_t                          display,
	output logic [datapath_pkg::ir_op_width-1:0]         ir_op,
	output logic [datapath_pkg::ir_rd_width-1:0]         ir_rd,
	output logic [datapath_pkg::ir_op2_width-1:0]        ir_op2,
	output logic [datapath_pkg::ir_op3_width-1:0]        ir_op3,
	output logic [datapath_pkg::ir_rs1_width-1:0]        ir_rs1,
	output logic                                         ir_bit13,
	output logic [datapath_pkg::ir_rs2_width-1:0]        ir_rs2
);
	import datapath_pkg::*;

	// r0 has no storage at all, the array starts at r1
	word_t regs [1:num_regs-1];
	logic [num_regs-1:1] write_en;
	word_t ir;

	// ------------------------------------------------------------------
	// write decoder, at most one enable is ever high
	// ------------------------------------------------------------------
	always_comb begin
		for (int i = 1; i < num_regs; i++) begin
			write_en[i] = exec && (write_sel == reg_sel_t'(i));
		end
	end

	// pc comes out of reset at the boot address, everything else at zero
	always_ff @(posedge clock_50) begin
		if (!rst_n) begin
			for (int i = 1; i < num_regs; i++) begin
				regs[i] <= (i == reg_pc) ? pc_reset_value : '0;
			end
		end else begin
			for (int i = 1; i < num_regs; i++) begin
				if (write_en[i]) begin
					regs[i] <= bus_c;
				end
			end
		end
	end

	// ------------------------------------------------------------------
	// read ports, zero unless the select hits a stored register
	// ------------------------------------------------------------------
	always_comb begin
		bus_a = '0;
		for (int i = 1; i < num_regs; i++) begin
			if (bus_a_sel == reg_sel_t'(i)) begin
				bus_a = regs[i];
			end
		end
	end

	always_comb begin
		bus_b = '0;
		for (int i = 1; i < num_regs; i++) begin
			if (bus_b_sel == reg_sel_t'(i)) begin
				bus_b = regs[i];
			end
		end
	end

	// instruction fields are plain slices of ir, no decoding happens here
	assign ir = regs[reg_ir];
	assign ir_op = ir[ir_op_lsb +: ir_op_width];
	assign ir_rd = ir[ir_rd_lsb +: ir_rd_width];
	assign ir_op2 = ir[ir_op2_lsb +: ir_op2_width];
	assign ir_op3 = ir[ir_op3_lsb +: ir_op3_width];
	assign ir_rs1 = ir[ir_rs1_lsb +: ir_rs1_width];
	assign ir_bit13 = ir[ir_bit13_lsb];
	assign ir_rs2 = ir[ir_rs2_lsb +: ir_rs2_width];

	// r1 doubles as the value shown on the display
	assign display = regs[reg_r1];

endmodule

`default_nettype wire

/* hdl/alu.sv */
/* purely combinational, flags are only candidates until the status register loads them
   v and c are meaningful for addcc alone and read as zero for every other opcode */
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  datapath_pkg::alu_op_t alu_op,
	input  datapath_pkg::word_t   bus_a,
	input  datapath_pkg::word_t   bus_b,
	output datapath_pkg::word_t   bus_c,
	output logic                  n_next,
	output logic                  z_next,
	output logic                  v_next,
	output logic                  c_next
);
	import datapath_pkg::*;

	// one extra bit on the sum catches the carry out of bit 31
	logic [data_width:0] add_sum;
	logic add_overflow;

	assign add_sum = {1'b0, bus_a} + {1'b0, bus_b};

	// signed overflow when both operands agree in sign and the sum does not
	assign add_overflow = (bus_a[data_width-1] == bus_b[data_width-1]) &&
		(add_sum[data_width-1] != bus_a[data_width-1]);

	// ------------------------------------------------------------------
	// result select
	// ------------------------------------------------------------------
	always_comb begin
		bus_c = '0;
		case (alu_op)
			alu_andcc, alu_and: begin
				bus_c = bus_a & bus_b;
			end
			alu_orcc, alu_or: begin
				bus_c = bus_a | bus_b;
			end
			alu_norcc, alu_nor: begin
				bus_c = ~(bus_a | bus_b);
			end
			alu_addcc, alu_add: begin
				bus_c = add_sum[data_width-1:0];
			end
			// only the low five bits of b count as the shift amount
			alu_srl: begin
				bus_c = bus_a >> bus_b[4:0];
			end
			alu_lshift2: begin
				bus_c = bus_a << 2;
			end
			alu_lshift10: begin
				bus_c = bus_a << 10;
			end
			// the 13-bit immediate of the instruction format
			alu_simm13: begin
				bus_c = {{(data_width-13){1'b0}}, bus_a[12:0]};
			end
			alu_sext13: begin
				bus_c = {{(data_width-13){bus_a[12]}}, bus_a[12:0]};
			end
			alu_inc: begin
				bus_c = bus_a + 1;
			end
			// step to the next instruction word
			alu_incpc: begin
				bus_c = bus_a + 4;
			end
			alu_rshift5: begin
				bus_c = $signed(bus_a) >>> 5;
			end
			default: begin
				bus_c = '0;
			end
		endcase
	end

	// n and z follow the result for every opcode
	assign n_next = bus_c[data_width-1];
	assign z_next = (bus_c == '0);
	assign v_next = (alu_op == alu_addcc) && add_overflow;
	assign c_next = (alu_op == alu_addcc) && add_sum[data_width];

endmodule

`default_nettype wire

/* hdl/status_register.sv */
/* holds only the n, z, v and c flags, all other psr bits are gone
   flags change only on exec and only for andcc, orcc, norcc and addcc */
`timescale 1ns/1ps
`default_nettype none

module status_register (
	input  logic                  clock_50,
	input  logic                  rst_n,
	input  logic                  exec,
	input  datapath_pkg::alu_op_t alu_op,
	input  logic                  n_next,
	input  logic                  z_next,
	input  logic                  v_next,
	input  logic                  c_next,
	output logic                  psr_n,
	output logic                  psr_z,
	output logic                  psr_v,
	output logic                  psr_c
);
	import datapath_pkg::*;

	logic cc_op;

	// the condition-code opcodes are the ones with both upper bits clear
	assign cc_op = alu_op inside {alu_andcc, alu_orcc, alu_norcc, alu_addcc};

	always_ff @(posedge clock_50) begin
		if (!rst_n) begin
			{psr_n, psr_z, psr_v, psr_c} <= 4'b0000;
		end else if (exec && cc_op) begin
			{psr_n, psr_z, psr_v, psr_c} <= {n_next, z_next, v_next, c_next};
		end
	end

endmodule

`default_nettype wire

/* hdl/ucode_datapath.sv */
/* one micro-operation per req/ack handshake, results are valid while ack is high
   pc_reset_value sets the boot address loaded into pc on reset */
`timescale 1ns/1ps
`default_nettype none

module ucode_datapath #(
	parameter datapath_pkg::word_t pc_reset_value = 32'h0000_0800
) (
	input  logic                                         clock_50,
	input  logic                                         rst_n,
	input  logic                                         req,
	output logic                                         ack,
	input  datapath_pkg::reg_sel_t                       write_sel,
	input  datapath_pkg::reg_sel_t                       bus_a_sel,
	input  datapath_pkg::reg_sel_t                       bus_b_sel,
	input  datapath_pkg::alu_op_t                        alu_op,
	output datapath_pkg::word_t                          display,
	output logic                                         psr_n,
	output logic                                         psr_z,
	output logic                                         psr_v,
	output logic                                         psr_c,
	output logic [datapath_pkg::ir_op_width-1:0]         ir_op,
	output logic [datapath_pkg::ir_rd_width-1:0]         ir_rd,
	output logic [datapath_pkg::ir_op2_width-1:0]        ir_op2,
	output logic [datapath_pkg::ir_op3_width-1:0]        ir_op3,
	output logic [datapath_pkg::ir_rs1_width-1:0]        ir_rs1,
	output logic                                         ir_bit13,
	output logic [datapath_pkg::ir_rs2_width-1:0]        ir_rs2
);
	import datapath_pkg::*;

	logic exec;
	word_t bus_a;
	word_t bus_b;
	word_t bus_c;
	logic n_next;
	logic z_next;
	logic v_next;
	logic c_next;

	// ------------------------------------------------------------------
	// handshake turns each request into a single exec cycle
	// ------------------------------------------------------------------
	micro_sequencer u_sequencer (
		.clock_50 (clock_50),
		.rst_n    (rst_n),
		.req      (req),
		.ack      (ack),
		.exec     (exec)
	);

	register_file #(
		.pc_reset_value (pc_reset_value)
	) u_register_file (
		.clock_50  (clock_50),
		.rst_n     (rst_n),
		.exec      (exec),
		.write_sel (write_sel),
		.bus_a_sel (bus_a_sel),
		.bus_b_sel (bus_b_sel),
		.bus_c     (bus_c),
		.bus_a     (bus_a),
		.bus_b     (bus_b),
		.display   (display),
		.ir_op     (ir_op),
		.ir_rd     (ir_rd),
		.ir_op2    (ir_op2),
		.ir_op3    (ir_op3),
		.ir_rs1    (ir_rs1),
		.ir_bit13  (ir_bit13),
		.ir_rs2    (ir_rs2)
	);

	// bus c loops back from the alu to the register file write port
	alu u_alu (
		.alu_op (alu_op),
		.bus_a  (bus_a),
		.bus_b  (bus_b),
		.bus_c  (bus_c),
		.n_next (n_next),
		.z_next (z_next),
		.v_next (v_next),
		.c_next (c_next)
	);

	status_register u_status_register (
		.clock_50 (clock_50),
		.rst_n    (rst_n),
		.exec     (exec),
		.alu_op   (alu_op),
		.n_next   (n_next),
		.z_next   (z_next),
		.v_next   (v_next),
		.c_next   (c_next),
		.psr_n    (psr_n),
		.psr_z    (psr_z),
		.psr_v    (psr_v),
		.psr_c    (psr_c)
	);

endmodule

`default_nettype wire

/* testbench/datapath_tb.sv */
/* runs a fixed table of micro-operations through the req/ack handshake
   expected values were worked out by hand from the opcode table, the flag rule and reset */
`timescale 1ns/1ps
`default_nettype none

module datapath_tb;
	import datapath_pkg::*;

	localparam int num_tests = 21;
	localparam int clk_period = 8;
	// 16 cycles per operation covers the handshake, the hold and the largest idle gap
	localparam int watchdog_ns = (num_tests * 16 + 5 + 40) * clk_period;

	localparam reg_sel_t sel_r0 = reg_sel_t'(reg_r0);
	localparam reg_sel_t sel_r1 = reg_sel_t'(reg_r1);
	localparam reg_sel_t sel_pc = reg_sel_t'(reg_pc);
	localparam reg_sel_t sel_t0 = reg_sel_t'(reg_t0);
	localparam reg_sel_t sel_t1 = reg_sel_t'(reg_t1);
	localparam reg_sel_t sel_t2 = reg_sel_t'(reg_t2);
	localparam reg_sel_t sel_t3 = reg_sel_t'(reg_t3);
	localparam reg_sel_t sel_ir = reg_sel_t'(reg_ir);
	// past the last register, so writes vanish and reads give zero
	localparam reg_sel_t sel_bad = 6'd40;

	logic clock_50;
	logic rst_n;
	logic req;
	logic ack;
	reg_sel_t write_sel;
	reg_sel_t bus_a_sel;
	reg_sel_t bus_b_sel;
	alu_op_t alu_op;
	word_t display;
	logic psr_n;
	logic psr_z;
	logic psr_v;
	logic psr_c;
	logic [ir_op_width-1:0] ir_op;
	logic [ir_rd_width-1:0] ir_rd;
	logic [ir_op2_width-1:0] ir_op2;
	logic [ir_op3_width-1:0] ir_op3;
	logic [ir_rs1_width-1:0] ir_rs1;
	logic ir_bit13;
	logic [ir_rs2_width-1:0] ir_rs2;

	// stimulus and expected results, flags packed as {n, z, v, c}
	reg_sel_t tab_write [num_tests];
	reg_sel_t tab_a [num_tests];
	reg_sel_t tab_b [num_tests];
	alu_op_t tab_op [num_tests];
	word_t tab_display [num_tests];
	logic [3:0] tab_flags [num_tests];
	logic tab_chk_ir [num_tests];
	word_t tab_ir [num_tests];
	int n_entries;
	int tests_passed;
	int tests_failed;
	logic test_bad;

	ucode_datapath #(
		.pc_reset_value (32'h0000_0800)
	) UUT (
		.clock_50  (clock_50),
		.rst_n     (rst_n),
		.req       (req),
		.ack       (ack),
		.write_sel (write_sel),
		.bus_a_sel (bus_a_sel),
		.bus_b_sel (bus_b_sel),
		.alu_op    (alu_op),
		.display   (display),
		.psr_n     (psr_n),
		.psr_z     (psr_z),
		.psr_v     (psr_v),
		.psr_c     (psr_c),
		.ir_op     (ir_op),
		.ir_rd     (ir_rd),
		.ir_op2    (ir_op2),
		.ir_op3    (ir_op3),
		.ir_rs1    (ir_rs1),
		.ir_bit13  (ir_bit13),
		.ir_rs2    (ir_rs2)
	);

	always #(clk_period / 2) clock_50 = ~clock_50;

	// ------------------------------------------------------------------
	// compare tasks, each marks the running test as bad on a mismatch
	// ------------------------------------------------------------------
	task automatic check_word(input string name, input word_t actual, input word_t expected);
		if (actual !== expected) begin
			$display("[FAIL] %s: got %h, expected %h", name, actual, expected);
			test_bad = 1'b1;
		end
	endtask

	task automatic check_flag(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			$display("[FAIL] %s: got %h, expected %h", name, actual, expected);
			test_bad = 1'b1;
		end
	endtask

	// the expected field is cut from the ir word at the package positions
	task automatic check_ir_field(input string name, input logic [5:0] actual,
		input word_t ir_word, input int lsb, input int width);
		word_t expected;
		begin
			expected = (ir_word >> lsb) & ((word_t'(1) << width) - word_t'(1));
			if (word_t'(actual) !== expected) begin
				$display("[FAIL] %s: got %h, expected %h", name, actual, expected);
				test_bad = 1'b1;
			end
		end
	endtask

	task automatic finish_test(input string name);
		if (test_bad) begin
			$display("%s FAILED", name);
			tests_failed++;
		end else begin
			$display("%s passed", name);
			tests_passed++;
		end
	endtask

	task automatic add_entry(input reg_sel_t w, input reg_sel_t a, input reg_sel_t b,
		input alu_op_t op, input word_t disp, input logic [3:0] flags,
		input logic chk_ir, input word_t ir_word);
		tab_write[n_entries] = w;
		tab_a[n_entries] = a;
		tab_b[n_entries] = b;
		tab_op[n_entries] = op;
		tab_display[n_entries] = disp;
		tab_flags[n_entries] = flags;
		tab_chk_ir[n_entries] = chk_ir;
		tab_ir[n_entries] = ir_word;
		n_entries++;
	endtask

	// ------------------------------------------------------------------
	// the micro-operation table
	// ------------------------------------------------------------------
	task automatic fill_table();
		// write-back through r1 and the temporaries, flags stay at reset
		add_entry(sel_r1, sel_pc, sel_r0, alu_incpc, 32'h0000_0804, 4'b0000, 1'b0, '0);
		add_entry(sel_r1, sel_r1, sel_r0, alu_lshift10, 32'h0020_1000, 4'b0000, 1'b0, '0);
		add_entry(sel_t1, sel_pc, sel_r0, alu_incpc, 32'h0020_1000, 4'b0000, 1'b0, '0);
		// t0 becomes 0x1008, which has bit 12 set
		add_entry(sel_t0, sel_t1, sel_t1, alu_add, 32'h0020_1000, 4'b0000, 1'b0, '0);
		add_entry(sel_r1, sel_t0, sel_r0, alu_sext13, 32'hffff_f008, 4'b0000, 1'b0, '0);
		// shift amount is t0[4:0], which is 8
		add_entry(sel_r1, sel_r1, sel_t0, alu_srl, 32'h00ff_fff0, 4'b0000, 1'b0, '0);
		add_entry(sel_r1, sel_r1, sel_r0, alu_nor, 32'hff00_000f, 4'b0000, 1'b0, '0);
		add_entry(sel_r1, sel_r1, sel_t0, alu_add, 32'hff00_1017, 4'b0000, 1'b0, '0);
		// build 0x7fffffff in t2 and 1 in t3
		add_entry(sel_t2, sel_r0, sel_r0, alu_nor, 32'hff00_1017, 4'b0000, 1'b0, '0);
		add_entry(sel_t3, sel_r0, sel_r0, alu_inc, 32'hff00_1017, 4'b0000, 1'b0, '0);
		add_entry(sel_t2, sel_t2, sel_t3, alu_srl, 32'hff00_1017, 4'b0000, 1'b0, '0);
		// condition codes, overflow then carry then a zero result
		add_entry(sel_r1, sel_t2, sel_t2, alu_addcc, 32'hffff_fffe, 4'b1010, 1'b0, '0);
		add_entry(sel_r1, sel_r1, sel_r1, alu_addcc, 32'hffff_fffc, 4'b1001, 1'b0, '0);
		add_entry(sel_r1, sel_r1, sel_r0, alu_andcc, 32'h0000_0000, 4'b0100, 1'b0, '0);
		// a plain add that overflows must leave the flags alone
		add_entry(sel_r1, sel_t2, sel_t3, alu_add, 32'h8000_0000, 4'b0100, 1'b0, '0);
		// writes to r0 and to select 40 are dropped
		add_entry(sel_r0, sel_t2, sel_r0, alu_or, 32'h8000_0000, 4'b0100, 1'b0, '0);
		add_entry(sel_bad, sel_t2, sel_r0, alu_or, 32'h8000_0000, 4'b0100, 1'b0, '0);
		add_entry(sel_r1, sel_r0, sel_bad, alu_add, 32'h0000_0000, 4'b0100, 1'b0, '0);
		// ir built through the alu, then checked field by field
		add_entry(sel_ir, sel_t0, sel_r0, alu_lshift10, 32'h0, 4'b0100, 1'b1, 32'h0040_2000);
		add_entry(sel_ir, sel_ir, sel_t2, alu_add, 32'h0, 4'b0100, 1'b1, 32'h8040_1fff);
		add_entry(sel_ir, sel_ir, sel_r0, alu_nor, 32'h0, 4'b0100, 1'b1, 32'h7fbf_e000);
	endtask

	// ------------------------------------------------------------------
	// one full four-phase handshake, entered just after a falling edge
	// ------------------------------------------------------------------
	task automatic run_op(input int idx);
		int waited;
		begin
			test_bad = 1'b0;
			write_sel = tab_write[idx];
			bus_a_sel = tab_a[idx];
			bus_b_sel = tab_b[idx];
			alu_op = tab_op[idx];
			req = 1'b1;
			// edge k has just sampled req, the sequencer is only in exec
			@(negedge clock_50);
			if (ack !== 1'b0) begin
				$display("test %0d: ack was already high at the edge that sampled req", idx);
				test_bad = 1'b1;
			end
			waited = 1;
			while (ack !== 1'b1 && waited < 8) begin
				@(negedge clock_50);
				waited++;
			end
			if (ack !== 1'b1) begin
				$display("test %0d: ack never rose after req", idx);
				test_bad = 1'b1;
			end else if (waited != 2) begin
				$display("test %0d: ack rose %0d edges after req instead of 2", idx, waited);
				test_bad = 1'b1;
			end
			// results are valid while ack is high
			check_word("display", display, tab_display[idx]);
			check_flag("psr_n", psr_n, tab_flags[idx][3]);
			check_flag("psr_z", psr_z, tab_flags[idx][2]);
			check_flag("psr_v", psr_v, tab_flags[idx][1]);
			check_flag("psr_c", psr_c, tab_flags[idx][0]);
			if (tab_chk_ir[idx]) begin
				check_ir_field("ir_op", 6'(ir_op), tab_ir[idx], ir_op_lsb, ir_op_width);
				check_ir_field("ir_rd", 6'(ir_rd), tab_ir[idx], ir_rd_lsb, ir_rd_width);
				check_ir_field("ir_op2", 6'(ir_op2), tab_ir[idx], ir_op2_lsb, ir_op2_width);
				check_ir_field("ir_op3", 6'(ir_op3), tab_ir[idx], ir_op3_lsb, ir_op3_width);
				check_ir_field("ir_rs1", 6'(ir_rs1), tab_ir[idx], ir_rs1_lsb, ir_rs1_width);
				check_ir_field("ir_bit13", 6'(ir_bit13), tab_ir[idx], ir_bit13_lsb,
					ir_bit13_width);
				check_ir_field("ir_rs2", 6'(ir_rs2), tab_ir[idx], ir_rs2_lsb, ir_rs2_width);
			end
			// keep req up a little longer, ack has to stay with it
			repeat (2) begin
				@(negedge clock_50);
				if (ack !== 1'b1) begin
					$display("test %0d: ack dropped while req was still high", idx);
					test_bad = 1'b1;
				end
			end
			req = 1'b0;
			@(negedge clock_50);
			if (ack !== 1'b0) begin
				$display("test %0d: ack stayed high after req was sampled low", idx);
				test_bad = 1'b1;
			end
			finish_test($sformatf("test %0d", idx));
		end
	endtask

	// ------------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------------
	initial begin
		void'($urandom(80));
		clock_50 = 1'b0;
		rst_n = 1'b0;
		req = 1'b0;
		write_sel = sel_r0;
		bus_a_sel = sel_r0;
		bus_b_sel = sel_r0;
		alu_op = alu_and;
		tests_passed = 0;
		tests_failed = 0;
		n_entries = 0;
		fill_table();
		repeat (5) @(negedge clock_50);
		rst_n = 1'b1;
		@(negedge clock_50);
		test_bad = 1'b0;
		check_flag("ack", ack, 1'b0);
		check_word("display", display, 32'h0000_0000);
		check_flag("psr_n", psr_n, 1'b0);
		check_flag("psr_z", psr_z, 1'b0);
		check_flag("psr_v", psr_v, 1'b0);
		check_flag("psr_c", psr_c, 1'b0);
		finish_test("reset test");
		for (int i = 0; i < n_entries; i++) begin
			run_op(i);
			repeat ($urandom % 8) @(negedge clock_50);
		end
		$display("tests passed %0d, tests failed %0d", tests_passed, tests_failed);
		if (tests_failed == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// a stuck handshake ends the run here
	initial begin
		#(watchdog_ns);
		$display("watchdog expired before all tests finished, the handshake stalled");
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
hdl/datapath_pkg.sv
hdl/micro_sequencer.sv
hdl/register_file.sv
hdl/alu.sv
hdl/status_register.sv
hdl/ucode_datapath.sv
testbench/datapath_tb.sv

/* Makefile */
# Verilator build and run for the microcode datapath

RTL = hdl/datapath_pkg.sv hdl/micro_sequencer.sv hdl/register_file.sv \
	hdl/alu.sv hdl/status_register.sv hdl/ucode_datapath.sv

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --top-module datapath_tb -f verilog.f \
		-Mdir obj_dir -o datapath_tb

# the run passes only if the log holds the pass message
run: build
	./obj_dir/datapath_tb | tee sim.log
	grep -q "Simulation completed successfully" sim.log

lint:
	verilator --lint-only -Wall --top-module ucode_datapath $(RTL)

clean:
	rm -rf obj_dir sim.log
